// File: Makefile
VERILATOR := verilator
TOP       := lsu_tb
FLIST     := flist.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!
FAIL_MSG  := Test failures found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
src/lsu_pkg.sv
src/lsu_data_align.sv
src/l1d_cache.sv
src/lsu_ctrl.sv
src/lsu_top.sv
verif/lsu_assert.sv
verif/lsu_bus_mem.sv
verif/lsu_tb.sv

// File: src/l1d_cache.sv
`timescale 1ns/100ps
`default_nettype none

module l1d_cache
  import lsu_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            reset_i,
  // lookup
  input  wire logic [XLEN-1:0] lookup_addr_i,
  output logic                 hit_o,
  output logic [XLEN-1:0]      rdata_o,
  // refill and invalidate
  input  wire logic            fill_i,
  input  wire logic [XLEN-1:0] fill_addr_i,
  input  wire logic [XLEN-1:0] fill_data_i,
  input  wire logic            inval_i,
  input  wire logic [XLEN-1:0] inval_addr_i
);

  logic [XLEN-1:0]      data_q [L1D_LINES];
  logic [L1D_TAG_W-1:0] tag_q  [L1D_LINES];
  logic [L1D_LINES-1:0] valid_q;

  logic [L1D_IDX_W-1:0] lk_idx;
  logic [L1D_TAG_W-1:0] lk_tag;
  logic [L1D_IDX_W-1:0] fill_idx;
  logic [L1D_TAG_W-1:0] fill_tag;
  logic [L1D_IDX_W-1:0] inv_idx;
  logic [L1D_TAG_W-1:0] inv_tag;
  logic                 inv_match;

  assign lk_idx   = lookup_addr_i[L1D_TAG_LSB-1:L1D_IDX_LSB];
  assign lk_tag   = lookup_addr_i[XLEN-1:L1D_TAG_LSB];
  assign fill_idx = fill_addr_i[L1D_TAG_LSB-1:L1D_IDX_LSB];
  assign fill_tag = fill_addr_i[XLEN-1:L1D_TAG_LSB];
  assign inv_idx  = inval_addr_i[L1D_TAG_LSB-1:L1D_IDX_LSB];
  assign inv_tag  = inval_addr_i[XLEN-1:L1D_TAG_LSB];

  // combinational lookup
  assign hit_o   = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign rdata_o = data_q[lk_idx];

  // store only kills the line it actually owns
  assign inv_match = valid_q[inv_idx] && (tag_q[inv_idx] == inv_tag);

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      valid_q <= '0;
    end
    else
    begin
      if (inval_i && inv_match)
      begin
        valid_q[inv_idx] <= 1'b0;
      end
      // refill last so it wins
      if (fill_i)
      begin
        valid_q[fill_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      data_q[fill_idx] <= fill_data_i;
      tag_q[fill_idx]  <= fill_tag;
    end
  end

endmodule

`default_nettype wire

// File: src/lsu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_ctrl
  import lsu_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_i,
  // core request and response
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  input  wire mem_op_t           req_op_i,
  input  wire logic [XLEN-1:0]   req_addr_i,
  input  wire logic [XLEN-1:0]   req_wdata_i,
  output logic                   resp_valid_o,
  input  wire logic              resp_ready_i,
  output logic [XLEN-1:0]        resp_rdata_o,
  // bus
  output logic                   bus_arvalid_o,
  input  wire logic              bus_arready_i,
  output logic [XLEN-1:0]        bus_araddr_o,
  input  wire logic              bus_rvalid_i,
  input  wire logic [XLEN-1:0]   bus_rdata_i,
  output logic                   bus_wvalid_o,
  input  wire logic              bus_wready_i,
  output logic [XLEN-1:0]        bus_awaddr_o,
  output logic [XLEN-1:0]        bus_wdata_o,
  output logic [STRB_W-1:0]      bus_wstrb_o,
  // cache
  output mem_op_t                op_o,
  output logic [XLEN-1:0]        addr_o,
  input  wire logic              cache_hit_i,
  input  wire logic [XLEN-1:0]   cache_rdata_i,
  output logic                   fill_o,
  output logic [XLEN-1:0]        fill_data_o,
  output logic                   inval_o,
  // alignment
  output logic [XLEN-1:0]        raw_word_o,
  input  wire logic [XLEN-1:0]   wdata_lane_i,
  input  wire logic [STRB_W-1:0] wstrb_i,
  input  wire logic [XLEN-1:0]   load_data_i
);

  lsu_state_t      state_q, state_d;
  mem_op_t         op_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] word_q;
  logic            accept;
  logic            req_store;
  logic            cacheable;

  assign accept    = req_valid_i && req_ready_o;
  assign req_store = req_op_i[3];
  assign cacheable = (addr_q >= CACHE_BASE) && (addr_q < CACHE_LIMIT);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE: if (accept) state_d = req_store ? S_W : (cache_hit_i ? S_RESP : S_AR);
      S_AR:   if (bus_arready_i) state_d = S_R;
      S_R:    if (bus_rvalid_i) state_d = S_RESP;
      S_W:    if (bus_wready_i) state_d = S_RESP;
      S_RESP: if (resp_ready_i) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset_i) state_q <= S_IDLE;
    else         state_q <= state_d;
  end

  // word_q holds store data for a store, the load word for a load
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q   <= req_op_i;
      addr_q <= req_addr_i;
      word_q <= req_store ? req_wdata_i : cache_rdata_i;
    end
    else if (state_q == S_R && bus_rvalid_i)
    begin
      word_q <= bus_rdata_i;
    end
  end

  // lookup follows the incoming request while idle
  assign addr_o = (state_q == S_IDLE) ? req_addr_i : addr_q;
  assign op_o   = op_q;

  assign inval_o     = accept && req_store;
  assign fill_o      = (state_q == S_R) && bus_rvalid_i && cacheable;
  assign fill_data_o = bus_rdata_i;

  assign req_ready_o   = (state_q == S_IDLE);
  assign resp_valid_o  = (state_q == S_RESP);
  assign resp_rdata_o  = load_data_i;
  assign raw_word_o    = word_q;
  assign bus_arvalid_o = (state_q == S_AR);
  assign bus_araddr_o  = {addr_q[XLEN-1:2], 2'b00};
  assign bus_wvalid_o  = (state_q == S_W);
  assign bus_awaddr_o  = {addr_q[XLEN-1:2], 2'b00};
  assign bus_wdata_o   = wdata_lane_i;
  assign bus_wstrb_o   = wstrb_i;

endmodule

`default_nettype wire

// File: src/lsu_data_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_data_align
  import lsu_pkg::*;
(
  input  wire mem_op_t          op_i,
  input  wire logic [1:0]       addr_lo_i,
  input  wire logic [XLEN-1:0]  store_data_i,
  input  wire logic [XLEN-1:0]  raw_word_i,
  output logic [STRB_W-1:0]     wstrb_o,
  output logic [XLEN-1:0]       wdata_lane_o,
  output logic [XLEN-1:0]       load_data_o
);

  logic [STRB_W-1:0] strb_base;
  logic [XLEN-1:0]   store_masked;
  logic [XLEN-1:0]   shifted;
  logic [4:0]        bit_ofs;

  // byte offset in bits
  assign bit_ofs = {addr_lo_i, 3'b000};

  // strobes and data before lane shift
  always_comb
  begin
    case (op_i)
      OP_SB:
      begin
        strb_base    = 4'b0001;
        store_masked = {24'h0, store_data_i[7:0]};
      end
      OP_SH:
      begin
        strb_base    = 4'b0011;
        store_masked = {16'h0, store_data_i[15:0]};
      end
      OP_SW:
      begin
        strb_base    = 4'b1111;
        store_masked = store_data_i;
      end
      default:
      begin
        strb_base    = '0;
        store_masked = '0;
      end
    endcase
  end

  assign wstrb_o      = strb_base << addr_lo_i;
  assign wdata_lane_o = store_masked << bit_ofs;

  // addressed byte down to bit 0
  assign shifted = raw_word_i >> bit_ofs;

  // extend to operation width, stores give zero
  always_comb
  begin
    case (op_i)
      OP_LB:   load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      OP_LBU:  load_data_o = {24'h0, shifted[7:0]};
      OP_LH:   load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      OP_LHU:  load_data_o = {16'h0, shifted[15:0]};
      OP_LW:   load_data_o = shifted;
      default: load_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // data and address width
  localparam int XLEN   = 32;
  localparam int STRB_W = XLEN / 8;

  // l1d geometry, one word per line
  localparam int L1D_LINES   = 8;
  localparam int L1D_IDX_W   = 3;
  localparam int L1D_IDX_LSB = 2;
  localparam int L1D_TAG_LSB = L1D_IDX_LSB + L1D_IDX_W;
  localparam int L1D_TAG_W   = XLEN - L1D_TAG_LSB;

  // only loads inside this window may fill the cache
  localparam logic [XLEN-1:0] CACHE_BASE  = 32'h8000_0000;
  localparam logic [XLEN-1:0] CACHE_LIMIT = 32'h8040_0000;

  // bit 3 set marks a store
  typedef enum logic [3:0] {
    OP_LB  = 4'h0,
    OP_LBU = 4'h1,
    OP_LH  = 4'h2,
    OP_LHU = 4'h3,
    OP_LW  = 4'h4,
    OP_SB  = 4'h8,
    OP_SH  = 4'h9,
    OP_SW  = 4'ha
  } mem_op_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_AR,
    S_R,
    S_W,
    S_RESP
  } lsu_state_t;

endpackage

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_i,
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  input  wire mem_op_t           req_op_i,
  input  wire logic [XLEN-1:0]   req_addr_i,
  input  wire logic [XLEN-1:0]   req_wdata_i,
  output logic                   resp_valid_o,
  input  wire logic              resp_ready_i,
  output logic [XLEN-1:0]        resp_rdata_o,
  output logic                   bus_arvalid_o,
  input  wire logic              bus_arready_i,
  output logic [XLEN-1:0]        bus_araddr_o,
  input  wire logic              bus_rvalid_i,
  input  wire logic [XLEN-1:0]   bus_rdata_i,
  output logic                   bus_wvalid_o,
  input  wire logic              bus_wready_i,
  output logic [XLEN-1:0]        bus_awaddr_o,
  output logic [XLEN-1:0]        bus_wdata_o,
  output logic [STRB_W-1:0]      bus_wstrb_o
);

  mem_op_t           op;
  logic [XLEN-1:0]   addr;
  logic              cache_hit;
  logic [XLEN-1:0]   cache_rdata;
  logic              fill;
  logic [XLEN-1:0]   fill_data;
  logic              inval;
  logic [XLEN-1:0]   raw_word;
  logic [XLEN-1:0]   wdata_lane;
  logic [STRB_W-1:0] wstrb;
  logic [XLEN-1:0]   load_data;

  lsu_ctrl i_lsu_ctrl (
    .clk, .reset_i,
    .req_valid_i, .req_ready_o, .req_op_i, .req_addr_i, .req_wdata_i,
    .resp_valid_o, .resp_ready_i, .resp_rdata_o,
    .bus_arvalid_o, .bus_arready_i, .bus_araddr_o, .bus_rvalid_i, .bus_rdata_i,
    .bus_wvalid_o, .bus_wready_i, .bus_awaddr_o, .bus_wdata_o, .bus_wstrb_o,
    .op_o (op), .addr_o (addr), .cache_hit_i (cache_hit), .cache_rdata_i (cache_rdata),
    .fill_o (fill), .fill_data_o (fill_data), .inval_o (inval),
    .raw_word_o (raw_word), .wdata_lane_i (wdata_lane), .wstrb_i (wstrb),
    .load_data_i (load_data)
  );

  // one address feeds lookup, refill and invalidate
  l1d_cache i_l1d_cache (
    .clk, .reset_i,
    .lookup_addr_i (addr), .hit_o (cache_hit), .rdata_o (cache_rdata),
    .fill_i (fill), .fill_addr_i (addr), .fill_data_i (fill_data),
    .inval_i (inval), .inval_addr_i (addr)
  );

  // payload register serves as store data and load word
  lsu_data_align i_lsu_data_align (
    .op_i (op), .addr_lo_i (addr[1:0]), .store_data_i (raw_word), .raw_word_i (raw_word),
    .wstrb_o (wstrb), .wdata_lane_o (wdata_lane), .load_data_o (load_data)
  );

endmodule

`default_nettype wire

// File: verif/lsu_assert.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_assert
  import lsu_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              reset_i,
  input  wire lsu_state_t        state_i,
  input  wire logic              req_valid_i,
  input  wire logic              req_ready_i,
  input  wire logic              resp_valid_i,
  input  wire logic              resp_ready_i,
  input  wire logic [XLEN-1:0]   resp_rdata_i,
  input  wire logic              arvalid_i,
  input  wire logic              arready_i,
  input  wire logic [XLEN-1:0]   araddr_i,
  input  wire logic              wvalid_i,
  input  wire logic              wready_i,
  input  wire logic [XLEN-1:0]   awaddr_i,
  input  wire logic [XLEN-1:0]   wdata_i,
  input  wire logic [STRB_W-1:0] wstrb_i
);

  // an accepted request always starts an operation
  accept_busy: assert property (@(posedge clk) disable iff (reset_i)
    (req_valid_i && req_ready_i) |=> (state_i != S_IDLE && !req_ready_i))
    else $error("request accepted without leaving the idle state");

  // ready comes back only once the response is taken
  ready_after_resp: assert property (@(posedge clk) disable iff (reset_i)
    $rose(req_ready_i) |-> $past(resp_valid_i && resp_ready_i))
    else $error("request ready again without a response handshake");

  resp_hold: assert property (@(posedge clk) disable iff (reset_i)
    (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_rdata_i)))
    else $error("response dropped or changed while stalled");

  ar_hold: assert property (@(posedge clk) disable iff (reset_i)
    (arvalid_i && !arready_i) |=> (arvalid_i && $stable(araddr_i)))
    else $error("read address dropped or changed while stalled");

  // write payload frozen under a stall
  w_hold: assert property (@(posedge clk) disable iff (reset_i)
    (wvalid_i && !wready_i) |=>
      (wvalid_i && $stable(awaddr_i) && $stable(wdata_i) && $stable(wstrb_i)))
    else $error("write channel dropped or changed while stalled");

  one_channel: assert property (@(posedge clk) disable iff (reset_i)
    !(arvalid_i && wvalid_i))
    else $error("read and write channels active together");

endmodule

`default_nettype wire

// File: verif/lsu_bus_mem.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_bus_mem (
  input  wire logic        clk,
  input  wire logic        reset_i,
  input  wire logic [31:0] rnd_i,
  input  wire logic        arvalid_i,
  output logic             arready_o,
  input  wire logic [31:0] araddr_i,
  output logic             rvalid_o,
  output logic [31:0]      rdata_o,
  input  wire logic        wvalid_i,
  output logic             wready_o,
  input  wire logic [31:0] awaddr_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic [3:0]  wstrb_i
);

  logic [31:0] mem [256];
  logic        rd_busy = 1'b0;
  logic [1:0]  rd_wait = 2'd0;
  logic [7:0]  rd_idx = 8'd0;
  logic        rvalid_q = 1'b0;
  logic [31:0] rdata_q = 32'h0;

  // every bit of the word index shows up in the pattern
  initial
  begin
    for (int i = 0; i < 256; i++)
    begin
      mem[i] <= {8'(i) ^ 8'ha5, 8'(i), ~8'(i), 8'(i) + 8'h3c};
    end
  end

  // upper generator bits, the low ones cycle too fast
  assign arready_o = rnd_i[31] | rnd_i[30];
  assign wready_o  = rnd_i[29] | rnd_i[28];
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;

  always @(posedge clk)
  begin
    rvalid_q <= 1'b0;
    if (reset_i)
    begin
      rd_busy <= 1'b0;
    end
    else if (arvalid_i && arready_o)
    begin
      rd_busy <= 1'b1;
      rd_idx  <= araddr_i[9:2];
      rd_wait <= rnd_i[27:26];
    end
    else if (rd_busy && rd_wait != 2'd0)
    begin
      rd_wait <= rd_wait - 2'd1;
    end
    else if (rd_busy)
    begin
      rd_busy  <= 1'b0;
      rvalid_q <= 1'b1;
      rdata_q  <= mem[rd_idx];
    end
    // upper address bits alias onto the 256 words
    if (!reset_i && wvalid_i && wready_o)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (wstrb_i[b])
        begin
          mem[awaddr_i[9:2]][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
();

  localparam int N_OPS   = 400;
  localparam int TIMEOUT = 50;

  logic              clk;
  logic              reset_i;
  logic              req_valid_i;
  logic              req_ready_o;
  mem_op_t           req_op_i;
  logic [XLEN-1:0]   req_addr_i;
  logic [XLEN-1:0]   req_wdata_i;
  logic              resp_valid_o;
  logic              resp_ready_i;
  logic [XLEN-1:0]   resp_rdata_o;
  logic              bus_arvalid_o;
  logic              bus_arready_i;
  logic [XLEN-1:0]   bus_araddr_o;
  logic              bus_rvalid_i;
  logic [XLEN-1:0]   bus_rdata_i;
  logic              bus_wvalid_o;
  logic              bus_wready_i;
  logic [XLEN-1:0]   bus_awaddr_o;
  logic [XLEN-1:0]   bus_wdata_o;
  logic [STRB_W-1:0] bus_wstrb_o;
  logic [31:0]       bus_rnd;

  logic [31:0]          lcg_state;
  logic [7:0]           mdl_mem [1024];
  logic                 mdl_valid [L1D_LINES];
  logic [L1D_TAG_W-1:0] mdl_tag [L1D_LINES];
  int                   errors;
  int                   ar_count;
  int                   hits;
  logic                 timed_out;

  // handshakes as the next rising edge will see them
  logic        req_hs;
  logic        resp_hs;
  logic        resp_seen;
  logic [31:0] resp_data;
  logic [31:0] ar_addr;
  logic [31:0] w_addr;
  logic [3:0]  w_strb;
  logic [31:0] w_data;

  mem_op_t op_list [8] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};

  lsu_top i_lsu_top (.*);

  lsu_bus_mem i_bus_mem (
    .clk, .reset_i, .rnd_i (bus_rnd),
    .arvalid_i (bus_arvalid_o), .arready_o (bus_arready_i), .araddr_i (bus_araddr_o),
    .rvalid_o (bus_rvalid_i), .rdata_o (bus_rdata_i),
    .wvalid_i (bus_wvalid_o), .wready_o (bus_wready_i), .awaddr_i (bus_awaddr_o),
    .wdata_i (bus_wdata_o), .wstrb_i (bus_wstrb_o)
  );

  bind lsu_top lsu_assert i_lsu_assert (
    .clk, .reset_i, .state_i (i_lsu_ctrl.state_q), .req_valid_i,
    .req_ready_i (req_ready_o),
    .resp_valid_i (resp_valid_o), .resp_ready_i, .resp_rdata_i (resp_rdata_o),
    .arvalid_i (bus_arvalid_o), .arready_i (bus_arready_i), .araddr_i (bus_araddr_o),
    .wvalid_i (bus_wvalid_o), .wready_i (bus_wready_i), .awaddr_i (bus_awaddr_o),
    .wdata_i (bus_wdata_o), .wstrb_i (bus_wstrb_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // pool words 0-7 and 8-15 share cache indexes, each owns a distinct memory word
  function automatic logic [31:0] pool_addr(input logic [4:0] w);
    logic [31:0] base;
    case (w[4:3])
      2'd0:    base = 32'h8000_0000;
      2'd1:    base = 32'h803f_fc00;
      2'd2:    base = 32'h8040_0000;
      default: base = 32'h0000_1000;
    endcase
    return base + {25'h0, w, 2'b00};
  endfunction

  function automatic logic [31:0] expected_load(input mem_op_t op, input logic [31:0] addr);
    logic [9:0] a;
    logic [7:0] b0;
    logic [7:0] b1;
    a  = addr[9:0];
    b0 = mdl_mem[a];
    b1 = mdl_mem[a + 10'd1];
    case (op)
      OP_LB:   return {{24{b0[7]}}, b0};
      OP_LBU:  return {24'h0, b0};
      OP_LH:   return {{16{b1[7]}}, b1, b0};
      OP_LHU:  return {16'h0, b1, b0};
      OP_LW:   return {mdl_mem[a + 10'd3], mdl_mem[a + 10'd2], b1, b0};
      default: return 32'h0;
    endcase
  endfunction

  // sample at the falling edge, then drive 2 ns past the rising edge
  task automatic step();
    logic [31:0] r;
    @(negedge clk);
    req_hs    = req_valid_i && req_ready_o;
    resp_hs   = resp_valid_o && resp_ready_i;
    resp_seen = resp_valid_o;
    resp_data = resp_rdata_o;
    if (bus_arvalid_o && bus_arready_i)
    begin
      ar_count++;
      ar_addr = bus_araddr_o;
    end
    if (bus_wvalid_o && bus_wready_i)
    begin
      w_addr = bus_awaddr_o;
      w_strb = bus_wstrb_o;
      w_data = bus_wdata_o;
    end
    @(posedge clk);
    #2;
    r            = next_rand();
    bus_rnd      = r;
    resp_ready_i = (r[25:24] != 2'b00);
  endtask

  task automatic run_op(input mem_op_t op, input logic [31:0] addr, input logic [31:0] wdata);
    logic                 store;
    logic                 cacheable;
    logic                 exp_hit;
    logic [L1D_IDX_W-1:0] idx;
    logic [L1D_TAG_W-1:0] tag;
    logic [31:0]          exp_data;
    logic [3:0]           exp_strb;
    logic [31:0]          exp_wdata;
    logic [31:0]          lane_mask;
    int                   nbytes;
    int                   ar_before;
    int                   waited;
    store     = op inside {OP_SB, OP_SH, OP_SW};
    cacheable = (addr >= CACHE_BASE) && (addr < CACHE_LIMIT);
    idx       = addr[4:2];
    tag       = addr[31:5];
    exp_hit   = !store && cacheable && mdl_valid[idx] && (mdl_tag[idx] == tag);
    exp_data  = expected_load(op, addr);
    nbytes    = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
    exp_strb  = (op == OP_SB) ? 4'b0001 : (op == OP_SH) ? 4'b0011 : 4'b1111;
    exp_strb  = exp_strb << addr[1:0];
    exp_wdata = 32'h0;
    lane_mask = 32'h0;
    if (store)
    begin
      // each stored byte lands in the lane of its address
      for (int k = 0; k < nbytes; k++)
      begin
        exp_wdata[8*(int'(addr[1:0]) + k) +: 8] = wdata[8*k +: 8];
        lane_mask[8*(int'(addr[1:0]) + k) +: 8] = 8'hff;
      end
    end
    ar_before = ar_count;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_hs = 1'b0;
    waited = 0;
    while (!req_hs)
    begin
      step();
      waited++;
      if (!req_hs && waited >= TIMEOUT)
      begin
        $display("ERROR: request not accepted within %0d cycles", TIMEOUT);
        errors++;
        timed_out = 1'b1;
        return;
      end
    end
    req_valid_i = 1'b0;
    resp_hs = 1'b0;
    waited  = 0;
    while (!resp_hs)
    begin
      step();
      waited++;
      if (waited == 1 && exp_hit && !resp_seen)
      begin
        $display("ERROR: cache hit at %h gave no response one cycle after acceptance", addr);
        errors++;
      end
      if (!resp_hs && waited >= TIMEOUT)
      begin
        $display("ERROR: no response within %0d cycles for address %h", TIMEOUT, addr);
        errors++;
        timed_out = 1'b1;
        return;
      end
    end
    if (resp_data !== exp_data)
    begin
      $display("MISMATCH at %0t: op %s addr %h expected %h got %h",
               $time, op.name(), addr, exp_data, resp_data);
      errors++;
    end
    if ((exp_hit || store) && ar_count != ar_before)
    begin
      $display("ERROR: bus read issued for a hit or a store at address %h", addr);
      errors++;
    end
    if (!exp_hit && !store && (ar_count != ar_before + 1 || ar_addr !== {addr[31:2], 2'b00}))
    begin
      $display("MISMATCH at %0t: miss at %h expected one bus read, got %0d reads, last at %h",
               $time, addr, ar_count - ar_before, ar_addr);
      errors++;
    end
    if (store && (w_strb !== exp_strb || w_addr !== {addr[31:2], 2'b00}
                  || (w_data & lane_mask) !== exp_wdata))
    begin
      $display("MISMATCH at %0t: store to %h expected strobe %b data %h got %b %h at %h",
               $time, addr, exp_strb, exp_wdata, w_strb, w_data & lane_mask, w_addr);
      errors++;
    end
    // update the reference copy and the cache model
    if (store)
    begin
      for (int k = 0; k < nbytes; k++)
      begin
        mdl_mem[addr[9:0] + 10'(k)] = wdata[8*k +: 8];
      end
      if (mdl_valid[idx] && mdl_tag[idx] == tag)
      begin
        mdl_valid[idx] = 1'b0;
      end
    end
    else if (exp_hit)
    begin
      hits++;
    end
    else if (cacheable)
    begin
      mdl_valid[idx] = 1'b1;
      mdl_tag[idx]   = tag;
    end
  endtask

  initial
  begin
    mem_op_t     op;
    logic [31:0] r;
    logic [31:0] addr;
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = OP_LW;
    req_addr_i   = 32'h0;
    req_wdata_i  = 32'h0;
    resp_ready_i = 1'b0;
    bus_rnd      = 32'h0;
    lcg_state    = 32'hc6e225c9;
    errors       = 0;
    ar_count     = 0;
    hits         = 0;
    timed_out    = 1'b0;
    for (int i = 0; i < 256; i++)
    begin
      mdl_mem[4*i]     = 8'(i) + 8'h3c;
      mdl_mem[4*i + 1] = ~8'(i);
      mdl_mem[4*i + 2] = 8'(i);
      mdl_mem[4*i + 3] = 8'(i) ^ 8'ha5;
    end
    for (int i = 0; i < L1D_LINES; i++)
    begin
      mdl_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #2;
    reset_i = 1'b0;
    for (int n = 0; n < N_OPS; n++)
    begin
      r    = next_rand();
      op   = op_list[r[31:29]];
      addr = pool_addr(r[28:24]);
      // halfwords on even addresses, words aligned
      if (op inside {OP_LB, OP_LBU, OP_SB})
      begin
        addr[1:0] = r[23:22];
      end
      else if (op inside {OP_LH, OP_LHU, OP_SH})
      begin
        addr[1] = r[23];
      end
      run_op(op, addr, next_rand());
      if (timed_out)
      begin
        break;
      end
    end
    $display("ops: %0d, cache hits: %0d, bus reads: %0d, errors: %0d",
             N_OPS, hits, ar_count, errors);
    if (errors == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
